/* rtl/dac_pkg.sv */
// DAC side definitions for two 10-bit parallel DACs; codes are offset binary, no sign bit
`default_nettype none

package dac_pkg;

  // --------------------------------------------------------------------------
  // Word format
  // --------------------------------------------------------------------------

  // Width of one DAC data bus
  localparam int DAC_W = 10;

  // One sample as sent to the DAC pins
  // Zero is the lowest output level, mid scale is 512
  typedef logic [DAC_W-1:0] dac_word_t;

  // --------------------------------------------------------------------------
  // Levels
  // --------------------------------------------------------------------------

  // Top code of the converter, 1023
  localparam dac_word_t FULL_SCALE = {DAC_W{1'b1}};

  // Square wave high level and triangle fold point use this
  // Sine table peaks a little below it

endpackage : dac_pkg

`default_nettype wire

/* rtl/dds_pkg.sv */
// Phase and waveform definitions for the DDS core; table is fixed at 256 points per period
`default_nettype none

package dds_pkg;

  // --------------------------------------------------------------------------
  // Phase
  // --------------------------------------------------------------------------

  // Table address width, top bits of each accumulator
  localparam int PHASE_W = 8;

  // Points in one waveform period
  localparam int TABLE_DEPTH = 2 ** PHASE_W;

  // One table address
  // MSB set means second half of the period
  typedef logic [PHASE_W-1:0] phase_t;

  // --------------------------------------------------------------------------
  // Waveform select
  // --------------------------------------------------------------------------

  // Per channel shape, 2 bits on the pins
  typedef enum logic [1:0] {
    WAVE_SINE   = 2'd0,  // ROM lookup
    WAVE_TRI    = 2'd1,  // Rising then falling ramp
    WAVE_SAW    = 2'd2,  // Phase scaled up to DAC width
    WAVE_SQUARE = 2'd3   // High in first half period
  } wave_e;

  // Only SINE touches the ROM
  // The other three are built from the address bits alone

endpackage : dds_pkg

`default_nettype wire

/* rtl/phase_accum.sv */
// Sample tick and phase accumulators; RATE_DIV must be even and >= 4, inputs sampled at the tick
`default_nettype none
`timescale 1ns/1ps

module phase_accum #(
  parameter int ACC_W    = 16,  // Accumulator width sets frequency resolution
  parameter int RATE_DIV = 8    // sys_clk cycles per sample
) (
  input  wire logic             sys_clk,
  input  wire logic             arst_n,
  input  wire logic             en,           // Pauses ticks and accumulators
  input  wire logic [ACC_W-1:0] freq_a,       // Phase step per sample for channel A
  input  wire logic [ACC_W-1:0] freq_b,       // Phase step per sample for channel B
  input  wire dds_pkg::phase_t  phase_off_b,  // Added to channel B address only
  output logic                  addr_stb,     // One cycle strobe with valid addresses
  output dds_pkg::phase_t       addr_a,
  output dds_pkg::phase_t       addr_b
);

  import dds_pkg::*;

  localparam int CNT_W = $clog2(RATE_DIV);
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(RATE_DIV - 1);

  logic [CNT_W-1:0] tick_cnt;  // Sample period divider
  logic             tick;      // Last cycle of a sample period
  logic [ACC_W-1:0] acc_a;     // Phase accumulator A
  logic [ACC_W-1:0] acc_b;     // Phase accumulator B
  phase_t           top_a;     // Table phase of A before the step
  phase_t           top_b;

  // --------------------------------------------------------------------------
  // Tick divider
  // --------------------------------------------------------------------------

  assign tick = en && (tick_cnt == CNT_LAST);

  always_ff @(posedge sys_clk or negedge arst_n) begin
    if (!arst_n) begin
      tick_cnt <= '0;
    end else if (en) begin
      if (tick) begin
        tick_cnt <= '0;  // Wrap
      end else begin
        tick_cnt <= tick_cnt + 1'b1;
      end
    end
    // Counter holds while en is low
  end

  // --------------------------------------------------------------------------
  // Accumulators
  // --------------------------------------------------------------------------

  assign top_a = acc_a[ACC_W-1 -: PHASE_W];
  assign top_b = acc_b[ACC_W-1 -: PHASE_W];

  // Address comes from the old value before the step is added
  always_ff @(posedge sys_clk or negedge arst_n) begin
    if (!arst_n) begin
      acc_a <= '0;
      acc_b <= '0;
    end else if (tick) begin
      acc_a <= acc_a + freq_a;  // Wraps mod 2**ACC_W
      acc_b <= acc_b + freq_b;
    end
  end

  // Strobe lands one cycle after the wrap
  always_ff @(posedge sys_clk or negedge arst_n) begin
    if (!arst_n) begin
      addr_stb <= 1'b0;
    end else begin
      addr_stb <= tick;
    end
  end

  // Addresses registered at the tick
  always_ff @(posedge sys_clk) begin
    if (tick) begin
      addr_a <= top_a;
      addr_b <= top_b + phase_off_b;  // Mod 256 offset for quadrature etc
    end
  end

endmodule : phase_accum

`default_nettype wire

/* rtl/wave_table.sv */
// Dual read waveform table; sine ROM loaded from rtl/sine_256x10.hex relative to the sim directory
`default_nettype none
`timescale 1ns/1ps

module wave_table (
  input  wire logic               sys_clk,
  input  wire logic               arst_n,
  input  wire logic               addr_stb,  // Addresses and selects valid
  input  wire dds_pkg::phase_t    addr_a,
  input  wire dds_pkg::phase_t    addr_b,
  input  wire dds_pkg::wave_e     wave_a,    // Shape for channel A
  input  wire dds_pkg::wave_e     wave_b,    // Shape for channel B
  output logic                    smp_stb,   // One cycle after addr_stb
  output dac_pkg::dac_word_t      smp_a,
  output dac_pkg::dac_word_t      smp_b
);

  import dac_pkg::*;
  import dds_pkg::*;

  // --------------------------------------------------------------------------
  // Sine ROM
  // --------------------------------------------------------------------------

  dac_word_t sine_rom [TABLE_DEPTH];  // One full period in offset binary

  initial begin
    $readmemh("rtl/sine_256x10.hex", sine_rom);
  end

  // --------------------------------------------------------------------------
  // Shape select
  // --------------------------------------------------------------------------

  // Same rule for both channels
  // sine is the ROM word already fetched for this phase
  function automatic dac_word_t shape(
    input wave_e     sel,
    input phase_t    ph,
    input dac_word_t sine
  );
    dac_word_t ramp;
    dac_word_t res;

    // Low 7 phase bits times 8 give 0..1016 over a half period
    ramp = {ph[PHASE_W-2:0], 3'b000};

    case (sel)
      WAVE_SINE:   res = sine;
      WAVE_TRI:    res = ph[PHASE_W-1] ? (FULL_SCALE - ramp) : ramp;  // Fold at 128
      WAVE_SAW:    res = {ph, 2'b00};                                  // Phase times 4
      WAVE_SQUARE: res = ph[PHASE_W-1] ? '0 : FULL_SCALE;             // High below 128
      default:     res = sine;
    endcase
    return res;
  endfunction

  // --------------------------------------------------------------------------
  // Output registers
  // --------------------------------------------------------------------------

  always_ff @(posedge sys_clk or negedge arst_n) begin
    if (!arst_n) begin
      smp_stb <= 1'b0;
    end else begin
      smp_stb <= addr_stb;  // Fixed one cycle latency
    end
  end

  // Two read ports on the same ROM for the two channels
  // Selects are taken together with the addresses
  always_ff @(posedge sys_clk) begin
    if (addr_stb) begin
      smp_a <= shape(wave_a, addr_a, sine_rom[addr_a]);
      smp_b <= shape(wave_b, addr_b, sine_rom[addr_b]);
    end
  end

endmodule : wave_table

`default_nettype wire

/* rtl/dac_driver.sv */
// DAC output stage; data changes with the DAC clock low, rising edge RATE_DIV/2 cycles later
`default_nettype none
`timescale 1ns/1ps

module dac_driver #(
  parameter int RATE_DIV = 8  // Even count of sys_clk cycles per sample
) (
  input  wire logic               sys_clk,
  input  wire logic               arst_n,
  input  wire logic               smp_stb,    // New sample pair
  input  wire dac_pkg::dac_word_t smp_a,
  input  wire dac_pkg::dac_word_t smp_b,
  output logic                    da_clk_a,   // DAC A latches on the rising edge
  output logic                    da_clk_b,   // DAC B latch clock
  output dac_pkg::dac_word_t      da_data_a,
  output dac_pkg::dac_word_t      da_data_b
);

  localparam int HALF   = RATE_DIV / 2;         // Low phase length
  localparam int HCNT_W = $clog2(HALF) + 1;
  localparam logic [HCNT_W-1:0] HCNT_LOAD = HCNT_W'(HALF - 1);

  logic [HCNT_W-1:0] half_cnt;  // Cycles left before the rising edge
  logic              pending;   // Low phase in progress
  logic              rise;      // Raise both clocks this cycle

  assign rise = pending && (half_cnt == '0);

  // --------------------------------------------------------------------------
  // Half period timer
  // --------------------------------------------------------------------------

  always_ff @(posedge sys_clk or negedge arst_n) begin
    if (!arst_n) begin
      half_cnt <= '0;
      pending  <= 1'b0;
    end else if (smp_stb) begin
      half_cnt <= HCNT_LOAD;  // Restart low phase
      pending  <= 1'b1;
    end else if (rise) begin
      pending  <= 1'b0;       // Clocks stay high until the next sample
    end else if (pending) begin
      half_cnt <= half_cnt - 1'b1;
    end
  end

  // --------------------------------------------------------------------------
  // Pin registers
  // --------------------------------------------------------------------------

  // Separate flops per pin
  // Lets each DAC clock be placed near its own pads
  always_ff @(posedge sys_clk or negedge arst_n) begin
    if (!arst_n) begin
      da_clk_a <= 1'b0;
      da_clk_b <= 1'b0;
    end else if (smp_stb) begin
      da_clk_a <= 1'b0;  // Fall with the data change
      da_clk_b <= 1'b0;
    end else if (rise) begin
      da_clk_a <= 1'b1;  // DAC latches here
      da_clk_b <= 1'b1;
    end
  end

  // Zero after reset so the pins start at the bottom code
  always_ff @(posedge sys_clk or negedge arst_n) begin
    if (!arst_n) begin
      da_data_a <= '0;
      da_data_b <= '0;
    end else if (smp_stb) begin
      da_data_a <= smp_a;  // Held until the next sample
      da_data_b <= smp_b;
    end
  end

endmodule : dac_driver

`default_nettype wire

/* rtl/dual_dds_dac.sv */
// Two channel DDS top; single clock sys_clk, arst_n expected already synchronised by the board
`default_nettype none
`timescale 1ns/1ps

module dual_dds_dac #(
  parameter int ACC_W    = 16,  // Phase accumulator width
  parameter int RATE_DIV = 8    // Clocks per sample must be even and >= 4
) (
  input  wire logic             sys_clk,
  input  wire logic             arst_n,
  input  wire logic             en,           // Low pauses both channels
  input  wire logic [ACC_W-1:0] freq_a,
  input  wire logic [ACC_W-1:0] freq_b,
  input  wire dds_pkg::phase_t  phase_off_b,  // Channel B phase lead
  input  wire logic [1:0]       wave_a,       // 0 sine 1 tri 2 saw 3 square
  input  wire logic [1:0]       wave_b,
  output logic                  da_clk_a,
  output dac_pkg::dac_word_t    da_data_a,
  output logic                  da_clk_b,
  output dac_pkg::dac_word_t    da_data_b
);

  import dac_pkg::*;
  import dds_pkg::*;

  // --------------------------------------------------------------------------
  // Internal links
  // --------------------------------------------------------------------------

  logic      addr_stb;  // Tick with valid addresses
  phase_t    addr_a;
  phase_t    addr_b;
  logic      smp_stb;   // Samples valid
  dac_word_t smp_a;
  dac_word_t smp_b;

  // Producer emits one address per channel per sample
  phase_accum #(
    .ACC_W    (ACC_W),
    .RATE_DIV (RATE_DIV)
  ) i_phase_accum (
    .sys_clk     (sys_clk),
    .arst_n      (arst_n),
    .en          (en),
    .freq_a      (freq_a),
    .freq_b      (freq_b),
    .phase_off_b (phase_off_b),
    .addr_stb    (addr_stb),
    .addr_a      (addr_a),
    .addr_b      (addr_b)
  );

  // Address to sample in one cycle
  wave_table i_wave_table (
    .sys_clk  (sys_clk),
    .arst_n   (arst_n),
    .addr_stb (addr_stb),
    .addr_a   (addr_a),
    .addr_b   (addr_b),
    .wave_a   (wave_e'(wave_a)),
    .wave_b   (wave_e'(wave_b)),
    .smp_stb  (smp_stb),
    .smp_a    (smp_a),
    .smp_b    (smp_b)
  );

  // Pin stage without back-pressure from the DACs
  dac_driver #(
    .RATE_DIV (RATE_DIV)
  ) i_dac_driver (
    .sys_clk   (sys_clk),
    .arst_n    (arst_n),
    .smp_stb   (smp_stb),
    .smp_a     (smp_a),
    .smp_b     (smp_b),
    .da_clk_a  (da_clk_a),
    .da_clk_b  (da_clk_b),
    .da_data_a (da_data_a),
    .da_data_b (da_data_b)
  );

endmodule : dual_dds_dac

`default_nettype wire

/* testbench/dual_dds_dac_checker.sv */
// DAC pin timing assertions, bound into dual_dds_dac; needs RATE_DIV equal to the DUT's value
`default_nettype none
`timescale 1ns/1ps

module dual_dds_dac_checker #(
  parameter int RATE_DIV = 8  // Must match the bound DUT
) (
  input  wire logic               sys_clk,
  input  wire logic               arst_n,
  input  wire logic               da_clk_a,
  input  wire logic               da_clk_b,
  input  wire dac_pkg::dac_word_t da_data_a,
  input  wire dac_pkg::dac_word_t da_data_b
);

  localparam int HALF = RATE_DIV / 2;  // Shortest legal high phase

  // --------------------------------------------------------------------------
  // Reset state
  // --------------------------------------------------------------------------

  a_clk_low_in_reset: assert property (
    @(posedge sys_clk) !arst_n |-> (!da_clk_a && !da_clk_b)
  ) else $error("DAC clock high while reset is asserted");

  // --------------------------------------------------------------------------
  // DAC latches data on the rising edge
  // --------------------------------------------------------------------------

  a_data_a_stable: assert property (
    @(posedge sys_clk) disable iff (!arst_n) da_clk_a |-> $stable(da_data_a)
  ) else $error("Channel A data changed while its DAC clock was high");

  a_data_b_stable: assert property (
    @(posedge sys_clk) disable iff (!arst_n) da_clk_b |-> $stable(da_data_b)
  ) else $error("Channel B data changed while its DAC clock was high");

  // High phase length is checked at the falling edge
  a_high_len_a: assert property (
    @(posedge sys_clk) disable iff (!arst_n) $fell(da_clk_a) |-> $past(da_clk_a, HALF)
  ) else $error("Channel A DAC clock high phase too short");

  a_high_len_b: assert property (
    @(posedge sys_clk) disable iff (!arst_n) $fell(da_clk_b) |-> $past(da_clk_b, HALF)
  ) else $error("Channel B DAC clock high phase too short");

endmodule : dual_dds_dac_checker

bind dual_dds_dac dual_dds_dac_checker #(
  .RATE_DIV (RATE_DIV)
) i_dual_dds_dac_checker (
  .sys_clk   (sys_clk),
  .arst_n    (arst_n),
  .da_clk_a  (da_clk_a),
  .da_clk_b  (da_clk_b),
  .da_data_a (da_data_a),
  .da_data_b (da_data_b)
);

`default_nettype wire

/* testbench/dual_dds_dac_tb.sv */
// DDS testbench; run from the project root so rtl/sine_256x10.hex is found, RATE_DIV fixed at 8
`default_nettype none
`timescale 1ns/1ps

module dual_dds_dac_tb;

  localparam int ACC_W    = 16;
  localparam int RATE_DIV = 8;

  logic             sys_clk;
  logic             arst_n;
  logic             en;
  logic [ACC_W-1:0] freq_a;
  logic [ACC_W-1:0] freq_b;
  logic [7:0]       phase_off_b;
  logic [1:0]       wave_a;
  logic [1:0]       wave_b;
  logic             da_clk_a;
  logic             da_clk_b;
  logic [9:0]       da_data_a;
  logic [9:0]       da_data_b;

  logic [9:0]       sine_ref [0:255];  // Same file as the ROM
  integer           seed;
  int               errors;
  int               edges_a = 0;       // Rising DAC clock edges seen
  int               edges_b = 0;
  logic [ACC_W-1:0] model_acc_a = '0;  // Model accumulators
  logic [ACC_W-1:0] model_acc_b = '0;
  logic             prev_clk_a = 1'b0;
  logic             prev_clk_b = 1'b0;
  string            test_name = "reset";
  int               held_edges_a;
  int               held_edges_b;
  logic [9:0]       held_a;
  logic [9:0]       held_b;

  dual_dds_dac #(
    .ACC_W    (ACC_W),
    .RATE_DIV (RATE_DIV)
  ) i_dual_dds_dac (
    .sys_clk     (sys_clk),
    .arst_n      (arst_n),
    .en          (en),
    .freq_a      (freq_a),
    .freq_b      (freq_b),
    .phase_off_b (phase_off_b),
    .wave_a      (wave_a),
    .wave_b      (wave_b),
    .da_clk_a    (da_clk_a),
    .da_data_a   (da_data_a),
    .da_clk_b    (da_clk_b),
    .da_data_b   (da_data_b)
  );

  always #5 sys_clk = ~sys_clk;  // 10 ns period

  // --------------------------------------------------------------------------
  // Reference model and checks
  // --------------------------------------------------------------------------

  // Expected DAC code for one table phase
  function automatic logic [9:0] expected_sample(input logic [7:0] ph, input logic [1:0] sel);
    int p;
    int ramp;
    int res;
    p    = int'(ph);
    ramp = (p % 128) * 8;
    case (sel)
      2'd0:    res = int'(sine_ref[ph]);
      2'd1:    res = (p < 128) ? ramp : 1023 - ramp;  // Up then down
      2'd2:    res = p * 4;
      default: res = (p < 128) ? 1023 : 0;
    endcase
    return 10'(res);
  endfunction

  task automatic check_value(input string name, input int expected, input int actual);
    if (expected !== actual) begin
      errors++;
      $display("[FAIL] %s: expected %0d, actual %0d", name, expected, actual);
    end
  endtask

  // Outputs settle after posedge, so sample on the falling edge
  always @(negedge sys_clk) begin : compare_a
    if (arst_n && da_clk_a && !prev_clk_a) begin
      check_value({test_name, " ch A"},
                  int'(expected_sample(model_acc_a[ACC_W-1 -: 8], wave_a)), int'(da_data_a));
      model_acc_a = model_acc_a + freq_a;
      edges_a     = edges_a + 1;
    end
    prev_clk_a = da_clk_a;
  end

  always @(negedge sys_clk) begin : compare_b
    logic [7:0] ph_b;
    ph_b = model_acc_b[ACC_W-1 -: 8] + phase_off_b;  // Offset wraps mod 256
    if (arst_n && da_clk_b && !prev_clk_b) begin
      check_value({test_name, " ch B"}, int'(expected_sample(ph_b, wave_b)), int'(da_data_b));
      model_acc_b = model_acc_b + freq_b;
      edges_b     = edges_b + 1;
    end
    prev_clk_b = da_clk_b;
  end

  // --------------------------------------------------------------------------
  // Stimulus helpers
  // --------------------------------------------------------------------------

  // Wait for count more edges on both channels, bounded
  task automatic wait_edges(input int count);
    int target_a;
    int target_b;
    int cycles;
    int limit;
    target_a = edges_a + count;
    target_b = edges_b + count;
    limit    = (count + 2) * RATE_DIV * 2;
    cycles   = 0;
    while ((edges_a < target_a || edges_b < target_b) && cycles < limit) begin
      @(posedge sys_clk);
      cycles++;
    end
    if (edges_a < target_a || edges_b < target_b) begin
      errors++;
      $display("Timeout in %s: DAC clock edges stopped arriving", test_name);
    end
  endtask

  // Pause, let the last sample reach the pins, then change the setup
  task automatic reconfigure(input logic [ACC_W-1:0] fa, input logic [ACC_W-1:0] fb,
                             input logic [1:0] wa, input logic [1:0] wb);
    @(posedge sys_clk);
    #1;
    en = 1'b0;
    repeat (2 * RATE_DIV) @(posedge sys_clk);
    #1;
    freq_a = fa;
    freq_b = fb;
    wave_a = wa;
    wave_b = wb;
    en     = 1'b1;
  endtask

  // --------------------------------------------------------------------------
  // Test sequence
  // --------------------------------------------------------------------------

  initial begin
    seed        = 41135;
    errors      = 0;
    sys_clk     = 1'b0;
    arst_n      = 1'b0;
    en          = 1'b1;
    freq_a      = 16'h0400;  // 64 samples per period
    freq_b      = 16'h0400;
    phase_off_b = 8'd64;     // Quadrature
    wave_a      = 2'd0;
    wave_b      = 2'd0;
    $readmemh("rtl/sine_256x10.hex", sine_ref);

    // Reset, pins low and zero
    repeat (8) @(posedge sys_clk);
    check_value("reset clk A", 0, int'(da_clk_a));
    check_value("reset clk B", 0, int'(da_clk_b));
    #1;
    arst_n = 1'b1;
    for (int i = 0; i < RATE_DIV; i++) begin
      @(negedge sys_clk);
      check_value("reset clk A", 0, int'(da_clk_a));
      check_value("reset clk B", 0, int'(da_clk_b));
      check_value("reset data A", 0, int'(da_data_a));
      check_value("reset data B", 0, int'(da_data_b));
    end

    // Two sine periods, B leads by a quarter
    test_name = "sine";
    wait_edges(128);

    // Computed shapes on channel A
    for (int sel = 1; sel < 4; sel++) begin
      test_name = $sformatf("shape %0d", sel);
      reconfigure(16'($random(seed)), freq_b, 2'(sel), 2'd0);
      wait_edges(40);
    end

    // Channels on their own words and shapes
    test_name = "independent";
    for (int r = 0; r < 4; r++) begin
      reconfigure(16'($random(seed)), 16'($random(seed)), 2'($random(seed)),
                  2'($random(seed)));
      wait_edges(32);
    end

    // Pause keeps pins and accumulators
    test_name = "enable";
    @(posedge sys_clk);
    #1;
    en = 1'b0;
    repeat (2 * RATE_DIV) @(posedge sys_clk);
    held_edges_a = edges_a;
    held_edges_b = edges_b;
    held_a       = da_data_a;
    held_b       = da_data_b;
    repeat (10 * RATE_DIV) @(posedge sys_clk);
    check_value("enable edges A", held_edges_a, edges_a);
    check_value("enable edges B", held_edges_b, edges_b);
    check_value("enable data A", int'(held_a), int'(da_data_a));
    check_value("enable data B", int'(held_b), int'(da_data_b));
    #1;
    en = 1'b1;
    wait_edges(24);  // Model resumes from its held values

    $display("Run finished with %0d error(s)", errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule : dual_dds_dac_tb

`default_nettype wire

/* rtl/sine_256x10.hex */
// Sine table, 256 words of 10 bits, offset binary, mid scale 0x200, peak 0x3FE
// One column per phase step, 16 words per line, address 0 at the top left
200 20D 219 226 232 23E 24B 257 263 270 27C 288 294 2A0 2AC 2B8
2C3 2CF 2DA 2E5 2F0 2FB 306 311 31B 326 330 33A 344 34D 356 360
369 371 37A 382 38A 392 39A 3A1 3A8 3AF 3B5 3BC 3C2 3C8 3CD 3D2
3D7 3DC 3E0 3E4 3E8 3EC 3EF 3F2 3F4 3F6 3F8 3FA 3FC 3FD 3FD 3FE
3FE 3FE 3FD 3FD 3FC 3FA 3F8 3F6 3F4 3F2 3EF 3EC 3E8 3E4 3E0 3DC
3D7 3D2 3CD 3C8 3C2 3BC 3B5 3AF 3A8 3A1 39A 392 38A 382 37A 371
369 360 356 34D 344 33A 330 326 31B 311 306 2FB 2F0 2E5 2DA 2CF
2C3 2B8 2AC 2A0 294 288 27C 270 263 257 24B 23E 232 226 219 20D
200 1F3 1E7 1DA 1CE 1C2 1B5 1A9 19D 190 184 178 16C 160 154 148
13D 131 126 11B 110 105 0FA 0EF 0E5 0DA 0D0 0C6 0BC 0B3 0AA 0A0
097 08F 086 07E 076 06E 066 05F 058 051 04B 044 03E 038 033 02E
029 024 020 01C 018 014 011 00E 00C 00A 008 006 004 003 003 002
002 002 003 003 004 006 008 00A 00C 00E 011 014 018 01C 020 024
029 02E 033 038 03E 044 04B 051 058 05F 066 06E 076 07E 086 08F
097 0A0 0AA 0B3 0BC 0C6 0D0 0DA 0E5 0EF 0FA 105 110 11B 126 131
13D 148 154 160 16C 178 184 190 19D 1A9 1B5 1C2 1CE 1DA 1E7 1F3

/* all.f */
rtl/dac_pkg.sv
rtl/dds_pkg.sv
rtl/phase_accum.sv
rtl/wave_table.sv
rtl/dac_driver.sv
rtl/dual_dds_dac.sv
testbench/dual_dds_dac_checker.sv
testbench/dual_dds_dac_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run with Verilator from the project root
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f all.f --top-module dual_dds_dac_tb -o dds_sim \
  || { echo "Build failed"; exit 1; }
./obj_dir/dds_sim > sim.log 2>&1
cat sim.log
grep -qx "NO ERRORS" sim.log && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
